// ==== source/usiPkg.sv ====
package usiPkg;

// ---------------------------------------------------------------------------
// Bus sizes
// ---------------------------------------------------------------------------
localparam int usiBusWidth     = 32;      // Data word
localparam int usiAdrsBit      = 32;      // Address word
localparam int busBlockConnect = 3;       // Slaves on the bus

// Address word layout
// {31:30} command, {23:16} block address, {15:0} CSR address
localparam int cmdMsb       = 31;
localparam int cmdLsb       = 30;
localparam int blockMsb     = 23;
localparam int blockLsb     = 16;
localparam int blockAdrsMap = 8;          // Block field width
localparam int csrWidth     = 8;          // Decoded CSR bits from bit 0

// Command codes, code 3 is reserved and ignored
localparam logic [1:0] cmdNone  = 2'd0;
localparam logic [1:0] cmdWrite = 2'd1;
localparam logic [1:0] cmdRead  = 2'd2;

// ---------------------------------------------------------------------------
// Block map
// ---------------------------------------------------------------------------
// Read slice and read-enable bit of a block sit at index map - 1
localparam logic [blockAdrsMap-1:0] gpioAdrsMap = 8'd1;
localparam logic [blockAdrsMap-1:0] sysAdrsMap  = 8'd2;
localparam logic [blockAdrsMap-1:0] ramAdrsMap  = 8'd3;

// Easy to spot in a waveform when block decode goes wrong
localparam logic [usiBusWidth-1:0] unmappedRd = 32'h1234_5678;

// GPIO block
localparam int                  gpioWidth  = 8;
localparam logic [csrWidth-1:0] gpioCsrOut = 8'd0;   // Output data
localparam logic [csrWidth-1:0] gpioCsrOe  = 8'd1;   // Output enable
localparam logic [csrWidth-1:0] gpioCsrIn  = 8'd2;   // Synchronized pins

// System block
localparam logic [usiBusWidth-1:0] sysId         = 32'h5553_0001;
localparam logic [csrWidth-1:0]    sysCsrId      = 8'd0;
localparam logic [csrWidth-1:0]    sysCsrScratch = 8'd1;
localparam logic [csrWidth-1:0]    sysCsrWrCnt   = 8'd2;

// RAM block
localparam int ramDepth = 256;            // One word per CSR address

endpackage

// ==== source/usiBus.sv ====
`timescale 1ns/1ps

module usiBus
	import usiPkg::*;
(
	input  logic                                   iUsiClk,
	input  logic                                   rstN,
	// Master side
	input  logic [usiBusWidth-1:0]                 iMUsiWd,    // Write data
	input  logic [usiAdrsBit-1:0]                  iMUsiAdrs,  // Cmd, block, CSR
	input  logic                                   iMUsiWEd,   // Command strobe
	output logic [usiBusWidth-1:0]                 oMUsiRd,
	output logic [busBlockConnect-1:0]             oMUsiREd,
	// Slave side, broadcast
	output logic [usiBusWidth-1:0]                 oSUsiWd,
	output logic [usiAdrsBit-1:0]                  oSUsiAdrs,
	output logic                                   oSUsiWCke,
	input  logic [usiBusWidth*busBlockConnect-1:0] iSUsiRd,    // Slices by block index
	input  logic [busBlockConnect-1:0]             iSUsiREd
);

logic [1:0]              mCmd;        // Command field of the master word
logic                    mCmdTake;    // Strobe with a usable command
logic [blockAdrsMap-1:0] blockD;      // Block field, aligned with slave reply

assign mCmd = iMUsiAdrs[cmdMsb:cmdLsb];

// Only write and read make it onto the bus
always_comb
begin
	case (mCmd)
		cmdWrite, cmdRead: mCmdTake = iMUsiWEd;
		cmdNone:           mCmdTake = 1'b0;
		default:           mCmdTake = 1'b0;   // Reserved code 3
	endcase
end

// ---------------------------------------------------------------------------
// Master to slave, one register stage
// ---------------------------------------------------------------------------
always_ff @(posedge iUsiClk)
begin
	if (!rstN)
		oSUsiWCke <= 1'b0;
	else
		oSUsiWCke <= mCmdTake;
end

always_ff @(posedge iUsiClk)
begin
	oSUsiWd   <= iMUsiWd;
	oSUsiAdrs <= iMUsiAdrs;
	// Slaves answer one cycle after seeing the command
	blockD    <= oSUsiAdrs[blockMsb:blockLsb];
end

// ---------------------------------------------------------------------------
// Slave to master, one register stage
// ---------------------------------------------------------------------------
always_ff @(posedge iUsiClk)
begin
	if (!rstN)
		oMUsiREd <= '0;
	else
		oMUsiREd <= iSUsiREd;           // Per-block enables pass straight up
end

// Read data mux by the delayed block field
always_ff @(posedge iUsiClk)
begin
	case (blockD)
		gpioAdrsMap: oMUsiRd <= iSUsiRd[usiBusWidth*(gpioAdrsMap-1) +: usiBusWidth];
		sysAdrsMap:  oMUsiRd <= iSUsiRd[usiBusWidth*(sysAdrsMap-1) +: usiBusWidth];
		ramAdrsMap:  oMUsiRd <= iSUsiRd[usiBusWidth*(ramAdrsMap-1) +: usiBusWidth];
		default:     oMUsiRd <= unmappedRd;  // No slave behind this block
	endcase
end

endmodule

// ==== source/usiGpioCsr.sv ====
`timescale 1ns/1ps

module usiGpioCsr
	import usiPkg::*;
(
	input  logic                   iUsiClk,
	input  logic                   rstN,
	input  logic [usiBusWidth-1:0] usiWd,
	input  logic [usiAdrsBit-1:0]  usiAdrs,
	input  logic                   usiWCke,
	input  logic [gpioWidth-1:0]   gpioIn,    // Asynchronous pins
	output logic [usiBusWidth-1:0] usiRd,
	output logic                   usiREd,
	output logic [gpioWidth-1:0]   gpioOut,
	output logic [gpioWidth-1:0]   gpioOe
);

logic                blockHit;    // Command for this block
logic                wrHit;
logic                rdHit;
logic [csrWidth-1:0] csrAdrs;
logic [gpioWidth-1:0] gpioSync1;  // First synchronizer stage
logic [gpioWidth-1:0] gpioSync2;  // Safe to read

// ---------------------------------------------------------------------------
// Address decode
// ---------------------------------------------------------------------------
assign blockHit = usiWCke && (usiAdrs[blockMsb:blockLsb] == gpioAdrsMap);
assign wrHit    = blockHit && (usiAdrs[cmdMsb:cmdLsb] == cmdWrite);
assign rdHit    = blockHit && (usiAdrs[cmdMsb:cmdLsb] == cmdRead);
assign csrAdrs  = usiAdrs[csrWidth-1:0];  // Upper CSR bits ignored

// Two-flop synchronizer on the pins
always_ff @(posedge iUsiClk)
begin
	gpioSync1 <= gpioIn;
	gpioSync2 <= gpioSync1;
end

// Output CSRs and read strobe
always_ff @(posedge iUsiClk)
begin
	if (!rstN)
	begin
		gpioOut <= '0;
		gpioOe  <= '0;            // Pins start as inputs
		usiREd  <= 1'b0;
	end
	else
	begin
		if (wrHit && csrAdrs == gpioCsrOut)
			gpioOut <= usiWd[gpioWidth-1:0];
		if (wrHit && csrAdrs == gpioCsrOe)
			gpioOe <= usiWd[gpioWidth-1:0];
		usiREd <= rdHit;          // One cycle per read
	end
end

// Read data, zero-extended, held between reads
always_ff @(posedge iUsiClk)
begin
	if (rdHit)
	begin
		case (csrAdrs)
			gpioCsrOut: usiRd <= {{(usiBusWidth-gpioWidth){1'b0}}, gpioOut};
			gpioCsrOe:  usiRd <= {{(usiBusWidth-gpioWidth){1'b0}}, gpioOe};
			gpioCsrIn:  usiRd <= {{(usiBusWidth-gpioWidth){1'b0}}, gpioSync2};
			default:    usiRd <= '0;
		endcase
	end
end

endmodule

// ==== source/usiSysCsr.sv ====
`timescale 1ns/1ps

module usiSysCsr
	import usiPkg::*;
(
	input  logic                   iUsiClk,
	input  logic                   rstN,
	input  logic [usiBusWidth-1:0] usiWd,
	input  logic [usiAdrsBit-1:0]  usiAdrs,
	input  logic                   usiWCke,
	output logic [usiBusWidth-1:0] usiRd,
	output logic                   usiREd
);

logic                   blockHit;
logic                   wrHit;    // Any write to this block
logic                   rdHit;
logic [csrWidth-1:0]    csrAdrs;
logic [usiBusWidth-1:0] scratch;  // Free read/write word
logic [usiBusWidth-1:0] wrCnt;    // Writes seen by this block

// ---------------------------------------------------------------------------
// Address decode
// ---------------------------------------------------------------------------
assign blockHit = usiWCke && (usiAdrs[blockMsb:blockLsb] == sysAdrsMap);
assign wrHit    = blockHit && (usiAdrs[cmdMsb:cmdLsb] == cmdWrite);
assign rdHit    = blockHit && (usiAdrs[cmdMsb:cmdLsb] == cmdRead);
assign csrAdrs  = usiAdrs[csrWidth-1:0];

always_ff @(posedge iUsiClk)
begin
	if (!rstN)
	begin
		scratch <= '0;
		wrCnt   <= '0;
		usiREd  <= 1'b0;
	end
	else
	begin
		// Only the scratch CSR stores data
		if (wrHit && csrAdrs == sysCsrScratch)
			scratch <= usiWd;
		// Counts writes to any CSR, read-only ones too
		if (wrHit)
			wrCnt <= wrCnt + 1'b1;
		usiREd <= rdHit;
	end
end

// Registered read data
always_ff @(posedge iUsiClk)
begin
	if (rdHit)
	begin
		case (csrAdrs)
			sysCsrId:      usiRd <= sysId;
			sysCsrScratch: usiRd <= scratch;
			sysCsrWrCnt:   usiRd <= wrCnt;
			default:       usiRd <= '0;
		endcase
	end
end

endmodule

// ==== source/usiRamBlock.sv ====
`timescale 1ns/1ps

module usiRamBlock
	import usiPkg::*;
(
	input  logic                   iUsiClk,
	input  logic                   rstN,
	input  logic [usiBusWidth-1:0] usiWd,
	input  logic [usiAdrsBit-1:0]  usiAdrs,
	input  logic                   usiWCke,
	output logic [usiBusWidth-1:0] usiRd,
	output logic                   usiREd
);

logic                   blockHit;
logic                   wrHit;
logic                   rdHit;
logic [csrWidth-1:0]    ramAdrs;              // Word address
logic [usiBusWidth-1:0] ramMem [ramDepth];    // Storage, one word per CSR

// ---------------------------------------------------------------------------
// Address decode
// ---------------------------------------------------------------------------
assign blockHit = usiWCke && (usiAdrs[blockMsb:blockLsb] == ramAdrsMap);
assign wrHit    = blockHit && (usiAdrs[cmdMsb:cmdLsb] == cmdWrite);
assign rdHit    = blockHit && (usiAdrs[cmdMsb:cmdLsb] == cmdRead);
assign ramAdrs  = usiAdrs[csrWidth-1:0];  // Low CSR bits cover all 256 words

// ---------------------------------------------------------------------------
// Memory array
// ---------------------------------------------------------------------------
always_ff @(posedge iUsiClk)
begin
	if (wrHit)
		ramMem[ramAdrs] <= usiWd;
end

// Read port, output held until the next read
always_ff @(posedge iUsiClk)
begin
	if (rdHit)
		usiRd <= ramMem[ramAdrs];
end

// Read strobe
always_ff @(posedge iUsiClk)
begin
	if (!rstN)
		usiREd <= 1'b0;
	else
		usiREd <= rdHit;      // High for the cycle usiRd is fresh
end

endmodule

// ==== source/usiSubsystem.sv ====
`timescale 1ns/1ps

module usiSubsystem
	import usiPkg::*;
(
	input  logic                       iUsiClk,
	input  logic                       rstN,
	// Master port
	input  logic [usiBusWidth-1:0]     iMUsiWd,
	input  logic [usiAdrsBit-1:0]      iMUsiAdrs,
	input  logic                       iMUsiWEd,
	output logic [usiBusWidth-1:0]     oMUsiRd,
	output logic [busBlockConnect-1:0] oMUsiREd,
	// GPIO pins
	input  logic [gpioWidth-1:0]       gpioIn,
	output logic [gpioWidth-1:0]       gpioOut,
	output logic [gpioWidth-1:0]       gpioOe
);

// Broadcast command toward every slave
logic [usiBusWidth-1:0]                 sUsiWd;
logic [usiAdrsBit-1:0]                  sUsiAdrs;
logic                                   sUsiWCke;
// Slave replies, packed by block index
logic [usiBusWidth*busBlockConnect-1:0] sUsiRd;
logic [busBlockConnect-1:0]             sUsiREd;

// ---------------------------------------------------------------------------
// Bus
// ---------------------------------------------------------------------------
usiBus bus (
	.iUsiClk   (iUsiClk),
	.rstN      (rstN),
	.iMUsiWd   (iMUsiWd),
	.iMUsiAdrs (iMUsiAdrs),
	.iMUsiWEd  (iMUsiWEd),
	.oMUsiRd   (oMUsiRd),
	.oMUsiREd  (oMUsiREd),
	.oSUsiWd   (sUsiWd),
	.oSUsiAdrs (sUsiAdrs),
	.oSUsiWCke (sUsiWCke),
	.iSUsiRd   (sUsiRd),
	.iSUsiREd  (sUsiREd)
);

// ---------------------------------------------------------------------------
// Slaves, each at slice map - 1
// ---------------------------------------------------------------------------
usiGpioCsr gpio (
	.iUsiClk (iUsiClk),
	.rstN    (rstN),
	.usiWd   (sUsiWd),
	.usiAdrs (sUsiAdrs),
	.usiWCke (sUsiWCke),
	.gpioIn  (gpioIn),
	.usiRd   (sUsiRd[usiBusWidth*(gpioAdrsMap-1) +: usiBusWidth]),
	.usiREd  (sUsiREd[gpioAdrsMap-1]),
	.gpioOut (gpioOut),
	.gpioOe  (gpioOe)
);

usiSysCsr sys (
	.iUsiClk (iUsiClk),
	.rstN    (rstN),
	.usiWd   (sUsiWd),
	.usiAdrs (sUsiAdrs),
	.usiWCke (sUsiWCke),
	.usiRd   (sUsiRd[usiBusWidth*(sysAdrsMap-1) +: usiBusWidth]),
	.usiREd  (sUsiREd[sysAdrsMap-1])
);

usiRamBlock ram (
	.iUsiClk (iUsiClk),
	.rstN    (rstN),
	.usiWd   (sUsiWd),
	.usiAdrs (sUsiAdrs),
	.usiWCke (sUsiWCke),
	.usiRd   (sUsiRd[usiBusWidth*(ramAdrsMap-1) +: usiBusWidth]),
	.usiREd  (sUsiREd[ramAdrsMap-1])
);

endmodule

// ==== dv/usiTb.sv ====
`timescale 1ns/1ps

module usiTb
	import usiPkg::*;
();

// ---------------------------------------------------------------------------
// Trace entry layout, 88 bits
// ---------------------------------------------------------------------------
// {87:84} op, {83:76} block, {75:68} csr, {67:36} data, {35:4} expected, {3:0} REd
localparam int         traceDepth   = 128;
localparam int         readLatency  = 3;       // Drive edge to data edge
localparam int         drainTimeout = 20;      // Cycles allowed for pending reads
localparam logic [1:0] cmdReserved  = 2'd3;

// Trace ops
localparam logic [3:0] opIdle          = 4'h0;
localparam logic [3:0] opWrite         = 4'h1;
localparam logic [3:0] opRead          = 4'h2;
localparam logic [3:0] opSetPins       = 4'h3;
localparam logic [3:0] opWriteNoStrobe = 4'h4;   // Write code, strobe low
localparam logic [3:0] opReservedCmd   = 4'h5;   // Code 3, strobe high
localparam logic [3:0] opNoneCmd       = 4'h6;   // Code 0, strobe high
localparam logic [3:0] opCheckPins     = 4'h7;   // Compare gpioOe and gpioOut
localparam logic [3:0] opEnd           = 4'hF;

logic                         iUsiClk;
logic                         rstN;
logic [usiBusWidth-1:0]       iMUsiWd;
logic [usiAdrsBit-1:0]        iMUsiAdrs;
logic                         iMUsiWEd;
logic [usiBusWidth-1:0]       oMUsiRd;
logic [busBlockConnect-1:0]   oMUsiREd;
logic [gpioWidth-1:0]         gpioIn;
logic [gpioWidth-1:0]         gpioOut;
logic [gpioWidth-1:0]         gpioOe;

logic [87:0]                  traceMem [traceDepth];
logic [87:0]                  entry;
logic [3:0]                   op;
logic [7:0]                   blk;
logic [7:0]                   csr;
logic [31:0]                  data;
logic [31:0]                  expData;
logic [busBlockConnect-1:0]   expREd;
logic                         traceDone;
int                           idx;
int                           cycle;        // Driver edge count
int                           sysWrCount;   // Writes to the system block
int                           drainCount;

// Reads in flight, oldest first
logic [31:0]                  expRdQ [$];
logic [busBlockConnect-1:0]   expREdQ [$];
int                           dueQ [$];
int                           entryQ [$];

usiSubsystem dut (
	.iUsiClk   (iUsiClk),
	.rstN      (rstN),
	.iMUsiWd   (iMUsiWd),
	.iMUsiAdrs (iMUsiAdrs),
	.iMUsiWEd  (iMUsiWEd),
	.oMUsiRd   (oMUsiRd),
	.oMUsiREd  (oMUsiREd),
	.gpioIn    (gpioIn),
	.gpioOut   (gpioOut),
	.gpioOe    (gpioOe)
);

initial
begin
	iUsiClk = 1'b0;
	forever #50 iUsiClk = ~iUsiClk;   // 100 ns period
end

// ---------------------------------------------------------------------------
// Helpers
// ---------------------------------------------------------------------------
task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
	input string what);
	if (actual !== expected)
	begin
		$display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
		$display("*** TEST FAILED ***");
		$fatal(1, "Value mismatch");
	end
endtask

task automatic abortRun(input string reason);
	$display("%s", reason);
	$display("*** TEST FAILED ***");
	$fatal(1, "Simulation stopped");
endtask

// Command word from its fields
function automatic logic [31:0] makeAdrs(input logic [1:0] cmd, input logic [7:0] block,
	input logic [7:0] csrAdrs);
	logic [31:0] adrs;
	adrs                    = '0;
	adrs[cmdMsb:cmdLsb]     = cmd;
	adrs[blockMsb:blockLsb] = block;
	adrs[csrWidth-1:0]      = csrAdrs;
	return adrs;
endfunction

// Advance one edge, bus idle unless the caller drives a command
task automatic nextCycle();
	@(posedge iUsiClk);
	cycle = cycle + 1;
	iMUsiWEd <= 1'b0;
endtask

// ---------------------------------------------------------------------------
// Response checker, samples at the falling edge
// ---------------------------------------------------------------------------
initial
begin
	forever
	begin
		@(negedge iUsiClk);
		if (dueQ.size() > 0 && dueQ[0] == cycle)
		begin
			checkValue(oMUsiRd, expRdQ[0], $sformatf("read data, trace entry %0d", entryQ[0]));
			checkValue({29'b0, oMUsiREd}, {29'b0, expREdQ[0]},
				$sformatf("read enables, trace entry %0d", entryQ[0]));
			void'(expRdQ.pop_front());
			void'(expREdQ.pop_front());
			void'(dueQ.pop_front());
			void'(entryQ.pop_front());
		end
		else if (dueQ.size() > 0 && dueQ[0] < cycle)
			abortRun("A read response was not checked in the cycle it was due");
	end
end

// ---------------------------------------------------------------------------
// Trace driver
// ---------------------------------------------------------------------------
initial
begin
	iMUsiWd    = '0;
	iMUsiAdrs  = '0;
	iMUsiWEd   = 1'b0;
	gpioIn     = '0;
	rstN       = 1'b0;
	cycle      = 0;
	sysWrCount = 0;
	drainCount = 0;
	traceDone  = 1'b0;
	$readmemh("dv/usiTrace.txt", traceMem);

	repeat (10) @(posedge iUsiClk);
	rstN <= 1'b1;

	for (idx = 0; idx < traceDepth && !traceDone; idx++)
	begin
		entry   = traceMem[idx];
		op      = entry[87:84];
		blk     = entry[83:76];
		csr     = entry[75:68];
		data    = entry[67:36];
		expData = entry[35:4];
		expREd  = entry[busBlockConnect-1:0];
		if (op == opEnd)
			traceDone = 1'b1;
		else
		begin
			nextCycle();
			case (op)
				opIdle: ;
				opWrite:
				begin
					iMUsiWEd  <= 1'b1;
					iMUsiAdrs <= makeAdrs(cmdWrite, blk, csr);
					iMUsiWd   <= data;
					if (blk == sysAdrsMap)
						sysWrCount = sysWrCount + 1;   // Any CSR counts
				end
				opRead:
				begin
					iMUsiWEd  <= 1'b1;
					iMUsiAdrs <= makeAdrs(cmdRead, blk, csr);
					iMUsiWd   <= data;
					expRdQ.push_back(expData);
					expREdQ.push_back(expREd);
					dueQ.push_back(cycle + readLatency);
					entryQ.push_back(idx);
					// Trace count must match the writes seen so far
					if (blk == sysAdrsMap && csr == sysCsrWrCnt)
						checkValue(expData, sysWrCount,
							$sformatf("write count in trace entry %0d", idx));
				end
				opSetPins:
					gpioIn <= data[gpioWidth-1:0];
				opWriteNoStrobe:
				begin
					iMUsiWEd  <= 1'b0;
					iMUsiAdrs <= makeAdrs(cmdWrite, blk, csr);
					iMUsiWd   <= data;
				end
				opReservedCmd:
				begin
					iMUsiWEd  <= 1'b1;
					iMUsiAdrs <= makeAdrs(cmdReserved, blk, csr);
					iMUsiWd   <= data;
				end
				opNoneCmd:
				begin
					iMUsiWEd  <= 1'b1;
					iMUsiAdrs <= makeAdrs(cmdNone, blk, csr);
					iMUsiWd   <= data;
				end
				opCheckPins:
				begin
					@(negedge iUsiClk);   // Pins settled
					checkValue({16'h0, gpioOe, gpioOut}, expData,
						$sformatf("GPIO pins, trace entry %0d", idx));
				end
				default:
					abortRun($sformatf("Unknown op %h in trace entry %0d", op, idx));
			endcase
		end
	end

	if (!traceDone)
		abortRun("The trace file has no end marker");

	// Let the last reads come back
	while (dueQ.size() > 0 && drainCount < drainTimeout)
	begin
		nextCycle();
		drainCount = drainCount + 1;
	end

	if (dueQ.size() == 0)
	begin
		$display("*** TEST PASSED ***");
		$finish;
	end
	else
	begin
		$display("Read responses were still pending when the drain wait timed out");
		$display("*** TEST FAILED ***");
		$fatal(1, "Drain timeout");
	end
end

endmodule

// ==== dv/usiTrace.txt ====
// op_block_csr_data_expected_red, hex, op 0 idle 1 wr 2 rd 3 pins 4 nostrobe
// 5 code3 6 code0 7 pin check {oe,out}, F end, red is the oMUsiREd vector
// System block ID, scratch and write counter
2_02_00_00000000_55530001_2
2_02_02_00000000_00000000_2
1_02_01_CAFEF00D_00000000_0
2_02_01_00000000_CAFEF00D_2
1_02_00_FFFFFFFF_00000000_0
2_02_00_00000000_55530001_2
2_02_02_00000000_00000002_2
2_02_05_00000000_00000000_2
// RAM words, back-to-back reads
1_03_00_00000011_00000000_0
1_03_FF_A5A5A5A5_00000000_0
1_03_80_12345000_00000000_0
1_03_01_DEADBEEF_00000000_0
2_03_00_00000000_00000011_4
2_03_FF_00000000_A5A5A5A5_4
2_03_80_00000000_12345000_4
2_03_01_00000000_DEADBEEF_4
1_03_00_0BADC0DE_00000000_0
2_03_00_00000000_0BADC0DE_4
// GPIO out and enable, pins then CSRs
1_01_00_000000C3_00000000_0
1_01_01_0000000F_00000000_0
0_00_00_00000000_00000000_0
0_00_00_00000000_00000000_0
7_00_00_00000000_00000FC3_0
2_01_00_00000000_000000C3_1
2_01_01_00000000_0000000F_1
3_00_00_0000005A_00000000_0
0_00_00_00000000_00000000_0
0_00_00_00000000_00000000_0
0_00_00_00000000_00000000_0
2_01_02_00000000_0000005A_1
1_01_00_FFFFFF3C_00000000_0
2_01_00_00000000_0000003C_1
// Unmapped blocks and mixed blocks back to back
2_07_00_00000000_12345678_0
2_00_00_00000000_12345678_0
2_FF_10_00000000_12345678_0
2_01_00_00000000_0000003C_1
2_02_00_00000000_55530001_2
2_07_00_00000000_12345678_0
2_03_FF_00000000_A5A5A5A5_4
// Ignored commands change nothing
4_02_01_11111111_00000000_0
5_02_01_22222222_00000000_0
6_02_01_33333333_00000000_0
4_01_00_00000000_00000000_0
5_01_01_000000FF_00000000_0
6_03_00_77777777_00000000_0
5_03_00_66666666_00000000_0
0_00_00_00000000_00000000_0
0_00_00_00000000_00000000_0
2_02_01_00000000_CAFEF00D_2
2_02_02_00000000_00000002_2
2_01_00_00000000_0000003C_1
7_00_00_00000000_00000F3C_0
2_03_00_00000000_0BADC0DE_4
// Write to the counter CSR still counts
1_02_02_00000099_00000000_0
2_02_02_00000000_00000003_2
F_00_00_00000000_00000000_0

// ==== vlog.f ====
source/usiPkg.sv
source/usiBus.sv
source/usiGpioCsr.sv
source/usiSysCsr.sv
source/usiRamBlock.sv
source/usiSubsystem.sv
dv/usiTb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = usiTb
FILELIST  = vlog.f
BUILDDIR  = obj_dir
LOG       = sim.log
PASSMSG   = *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASSMSG)" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
